// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module tb_instr_decode -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_instr_decode); echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

// ==== hdl/d_format_decoder.sv ====
`timescale 1ns/1ps

module d_format_decoder #(
	parameter int addr_width = 64
) (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic valid_i,
	input  logic [0:ppc_isa_pkg::instr_width-1] instruction_i,
	input  logic [0:addr_width-1] pc_i,
	output logic valid_o,
	output logic hit_o,
	output logic [0:ppc_isa_pkg::opcode_width-1] opcode_o,
	output logic [0:decode_pkg::kind_width-1] kind_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg1_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg2_o,
	output logic [0:decode_pkg::imm_width-1] imm_o,
	output logic ra_zero_o,
	output logic [0:addr_width-1] pc_o
);

	import ppc_isa_pkg::*;
	import decode_pkg::*;

	instr_word_u word;

	logic hit_c;
	logic [0:kind_width-1] kind_c;
	logic [0:imm_width-1] imm_c;
	logic ra_zero_c;

	// the d field extended both ways for the opcode case below.
	logic [0:imm_width-1] d_sext;
	logic [0:imm_width-1] d_zext;

	assign word = instruction_i;

	assign d_sext = {{(imm_width-d_width){word.d.d[0]}}, word.d.d};
	assign d_zext = {{(imm_width-d_width){1'b0}}, word.d.d};

	always_comb begin
		hit_c = valid_i;
		kind_c = k_none;
		imm_c = d_sext;
		// ra of zero means a literal zero, not r0.
		ra_zero_c = 1'b1;
		case (word.d.opcode)
			op_addi: begin
				kind_c = k_add;
			end
			op_addis: begin
				kind_c = k_add_shifted;
				imm_c = {d_sext[d_width:imm_width-1], {d_width{1'b0}}};
			end
			op_ori: begin
				// logical immediates are unsigned and use ra as a real register.
				kind_c = k_or_imm;
				imm_c = d_zext;
				ra_zero_c = 1'b0;
			end
			op_lwz: begin
				kind_c = k_load_word;
			end
			op_stw: begin
				kind_c = k_store_word;
			end
			default: begin
				hit_c = 1'b0;
			end
		endcase
	end

	// stage control.
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			hit_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			hit_o <= hit_c;
		end
	end

	// the payload registers also carry the pc for the whole stage.
	always_ff @(posedge clock_i) begin
		if (valid_i) begin
			opcode_o <= word.d.opcode;
			kind_o <= kind_c;
			reg1_o <= word.d.rt;
			reg2_o <= word.d.ra;
			imm_o <= imm_c;
			ra_zero_o <= ra_zero_c;
			pc_o <= pc_i;
		end
	end

endmodule

// ==== hdl/decode_pkg.sv ====
// micro-op definitions shared by the format decoders and the selector.
package decode_pkg;

	// immediate width of the decoded micro-op.
	localparam int imm_width = 64;

	// width of the operation kind code.
	localparam int kind_width = 4;

	// illegal words are the only ones that carry no operation.
	localparam logic [0:kind_width-1] k_none = 4'd0;

	// arithmetic and logical immediates.
	localparam logic [0:kind_width-1] k_add         = 4'd1;
	localparam logic [0:kind_width-1] k_add_shifted = 4'd2;
	localparam logic [0:kind_width-1] k_or_imm      = 4'd3;

	// word loads and stores, D-form.
	localparam logic [0:kind_width-1] k_load_word  = 4'd4;
	localparam logic [0:kind_width-1] k_store_word = 4'd5;

	// doubleword loads, DS-form.
	localparam logic [0:kind_width-1] k_load_dword     = 4'd6;
	localparam logic [0:kind_width-1] k_load_dword_upd = 4'd7;
	// lwa sign-extends the loaded word.
	localparam logic [0:kind_width-1] k_load_word_alg  = 4'd8;

	// doubleword and quadword stores, DS-form.
	localparam logic [0:kind_width-1] k_store_dword     = 4'd9;
	localparam logic [0:kind_width-1] k_store_dword_upd = 4'd10;
	localparam logic [0:kind_width-1] k_store_quad      = 4'd11;

endpackage

// ==== hdl/decode_select.sv ====
`timescale 1ns/1ps

module decode_select #(
	parameter int addr_width = 64
) (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic valid_i,
	input  logic d_hit_i,
	input  logic ds_hit_i,
	input  logic [0:ppc_isa_pkg::opcode_width-1] opcode_i,
	input  logic [0:decode_pkg::kind_width-1] d_kind_i,
	input  logic [0:decode_pkg::kind_width-1] ds_kind_i,
	input  logic [0:ppc_isa_pkg::reg_width-1] d_reg1_i,
	input  logic [0:ppc_isa_pkg::reg_width-1] d_reg2_i,
	input  logic [0:ppc_isa_pkg::reg_width-1] ds_reg1_i,
	input  logic [0:ppc_isa_pkg::reg_width-1] ds_reg2_i,
	input  logic [0:decode_pkg::imm_width-1] d_imm_i,
	input  logic [0:decode_pkg::imm_width-1] ds_imm_i,
	input  logic d_ra_zero_i,
	input  logic ds_ra_zero_i,
	input  logic [0:addr_width-1] pc_i,
	output logic valid_o,
	output logic illegal_o,
	output logic [0:ppc_isa_pkg::opcode_width-1] opcode_o,
	output logic [0:decode_pkg::kind_width-1] kind_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg1_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg2_o,
	output logic [0:decode_pkg::imm_width-1] imm_o,
	output logic ra_zero_o,
	output logic [0:addr_width-1] pc_o
);

	import decode_pkg::*;

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			illegal_o <= valid_i && !d_hit_i && !ds_hit_i;
		end
	end

	// the hit sets are disjoint by opcode, so at most one decoder hits.
	always_ff @(posedge clock_i) begin
		if (valid_i) begin
			opcode_o <= opcode_i;
			pc_o <= pc_i;
			if (ds_hit_i) begin
				kind_o <= ds_kind_i;
				reg1_o <= ds_reg1_i;
				reg2_o <= ds_reg2_i;
				imm_o <= ds_imm_i;
				ra_zero_o <= ds_ra_zero_i;
			end else begin
				// D fields also serve as filler for illegal words.
				kind_o <= d_hit_i ? d_kind_i : k_none;
				reg1_o <= d_reg1_i;
				reg2_o <= d_reg2_i;
				imm_o <= d_imm_i;
				ra_zero_o <= d_ra_zero_i;
			end
		end
	end

endmodule

// ==== hdl/ds_format_decoder.sv ====
`timescale 1ns/1ps

module ds_format_decoder #(
	parameter int addr_width = 64
) (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic valid_i,
	input  logic [0:ppc_isa_pkg::instr_width-1] instruction_i,
	output logic hit_o,
	output logic [0:ppc_isa_pkg::opcode_width-1] opcode_o,
	output logic [0:decode_pkg::kind_width-1] kind_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg1_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg2_o,
	output logic [0:decode_pkg::imm_width-1] imm_o,
	output logic ra_zero_o
);

	import ppc_isa_pkg::*;
	import decode_pkg::*;

	instr_word_u word;

	logic hit_c;
	logic [0:kind_width-1] kind_c;
	logic ra_zero_c;

	// the word-aligned displacement is sign-extended to the immediate width.
	logic [0:imm_width-1] disp_c;

	assign word = instruction_i;

	assign disp_c = {{(imm_width-ds_width-2){word.ds.ds[0]}}, word.ds.ds, 2'b00};

	always_comb begin
		hit_c = 1'b0;
		kind_c = k_none;
		ra_zero_c = 1'b1;
		if (valid_i) begin
			case (word.ds.opcode)
				op_ds_load: begin
					hit_c = 1'b1;
					case (word.ds.xo)
						xo_ld: kind_c = k_load_dword;
						xo_ldu: begin
							// update form writes the address back into ra.
							kind_c = k_load_dword_upd;
							ra_zero_c = 1'b0;
						end
						xo_lwa: kind_c = k_load_word_alg;
						default: hit_c = 1'b0;
					endcase
				end
				op_ds_store: begin
					hit_c = 1'b1;
					case (word.ds.xo)
						xo_std: kind_c = k_store_dword;
						xo_stdu: begin
							kind_c = k_store_dword_upd;
							ra_zero_c = 1'b0;
						end
						xo_stq: kind_c = k_store_quad;
						default: hit_c = 1'b0;
					endcase
				end
				default: hit_c = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= hit_c;
		end
	end

	always_ff @(posedge clock_i) begin
		if (valid_i) begin
			opcode_o <= word.ds.opcode;
			kind_o <= kind_c;
			reg1_o <= word.ds.rt;
			reg2_o <= word.ds.ra;
			imm_o <= disp_c;
			ra_zero_o <= ra_zero_c;
		end
	end

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode #(
	parameter int addr_width = 64
) (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic valid_i,
	input  logic [0:ppc_isa_pkg::instr_width-1] instruction_i,
	input  logic [0:addr_width-1] pc_i,
	output logic valid_o,
	output logic illegal_o,
	output logic [0:ppc_isa_pkg::opcode_width-1] opcode_o,
	output logic [0:decode_pkg::kind_width-1] kind_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg1_o,
	output logic [0:ppc_isa_pkg::reg_width-1] reg2_o,
	output logic [0:decode_pkg::imm_width-1] imm_o,
	output logic ra_zero_o,
	output logic [0:addr_width-1] pc_o
);

	import ppc_isa_pkg::*;
	import decode_pkg::*;

	logic d_valid;
	logic d_hit;
	logic ds_hit;
	logic [0:opcode_width-1] d_opcode;
	logic [0:kind_width-1] d_kind;
	logic [0:kind_width-1] ds_kind;
	logic [0:reg_width-1] d_reg1;
	logic [0:reg_width-1] d_reg2;
	logic [0:reg_width-1] ds_reg1;
	logic [0:reg_width-1] ds_reg2;
	logic [0:imm_width-1] d_imm;
	logic [0:imm_width-1] ds_imm;
	logic d_ra_zero;
	logic ds_ra_zero;
	logic [0:addr_width-1] d_pc;

	d_format_decoder #(
		.addr_width(addr_width)
	) u_d_dec (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.instruction_i(instruction_i),
		.pc_i(pc_i),
		.valid_o(d_valid),
		.hit_o(d_hit),
		.opcode_o(d_opcode),
		.kind_o(d_kind),
		.reg1_o(d_reg1),
		.reg2_o(d_reg2),
		.imm_o(d_imm),
		.ra_zero_o(d_ra_zero),
		.pc_o(d_pc)
	);

	// the D decoder holds the same opcode bits, so this copy stays open.
	ds_format_decoder #(
		.addr_width(addr_width)
	) u_ds_dec (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.instruction_i(instruction_i),
		.hit_o(ds_hit),
		.opcode_o(),
		.kind_o(ds_kind),
		.reg1_o(ds_reg1),
		.reg2_o(ds_reg2),
		.imm_o(ds_imm),
		.ra_zero_o(ds_ra_zero)
	);

	decode_select #(
		.addr_width(addr_width)
	) u_select (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.valid_i(d_valid),
		.d_hit_i(d_hit),
		.ds_hit_i(ds_hit),
		.opcode_i(d_opcode),
		.d_kind_i(d_kind),
		.ds_kind_i(ds_kind),
		.d_reg1_i(d_reg1),
		.d_reg2_i(d_reg2),
		.ds_reg1_i(ds_reg1),
		.ds_reg2_i(ds_reg2),
		.d_imm_i(d_imm),
		.ds_imm_i(ds_imm),
		.d_ra_zero_i(d_ra_zero),
		.ds_ra_zero_i(ds_ra_zero),
		.pc_i(d_pc),
		.valid_o(valid_o),
		.illegal_o(illegal_o),
		.opcode_o(opcode_o),
		.kind_o(kind_o),
		.reg1_o(reg1_o),
		.reg2_o(reg2_o),
		.imm_o(imm_o),
		.ra_zero_o(ra_zero_o),
		.pc_o(pc_o)
	);

endmodule

// ==== hdl/ppc_isa_pkg.sv ====
// instruction set definitions for the supported D and DS forms.
// bit numbering is big-endian, so bit 0 is the most significant bit.
package ppc_isa_pkg;

	// word and field widths.
	localparam int instr_width  = 32;
	localparam int opcode_width = 6;
	localparam int reg_width    = 5;
	localparam int d_width      = 16;
	localparam int ds_width     = 14;
	localparam int xo_ds_width  = 2;

	// primary opcodes, D-form.
	localparam logic [0:opcode_width-1] op_addi  = 6'd14;
	localparam logic [0:opcode_width-1] op_addis = 6'd15;
	localparam logic [0:opcode_width-1] op_ori   = 6'd24;
	localparam logic [0:opcode_width-1] op_lwz   = 6'd32;
	localparam logic [0:opcode_width-1] op_stw   = 6'd36;

	// primary opcodes, DS-form.
	// the low two bits of the word select the operation.
	localparam logic [0:opcode_width-1] op_ds_load  = 6'd58;
	localparam logic [0:opcode_width-1] op_ds_store = 6'd62;

	// sub-opcodes under op_ds_load.
	localparam logic [0:xo_ds_width-1] xo_ld  = 2'd0;
	localparam logic [0:xo_ds_width-1] xo_ldu = 2'd1;
	localparam logic [0:xo_ds_width-1] xo_lwa = 2'd2;

	// sub-opcodes under op_ds_store.
	localparam logic [0:xo_ds_width-1] xo_std  = 2'd0;
	localparam logic [0:xo_ds_width-1] xo_stdu = 2'd1;
	localparam logic [0:xo_ds_width-1] xo_stq  = 2'd2;

	// one instruction word, seen either as D-form or as DS-form.
	// both views share opcode, rt and ra in bits 0 to 15.
	typedef union packed {
		struct packed {
			logic [0:opcode_width-1] opcode;
			logic [0:reg_width-1]    rt;
			logic [0:reg_width-1]    ra;
			logic [0:d_width-1]      d;
		} d;
		struct packed {
			logic [0:opcode_width-1] opcode;
			logic [0:reg_width-1]    rt;
			logic [0:reg_width-1]    ra;
			logic [0:ds_width-1]     ds;
			logic [0:xo_ds_width-1]  xo;
		} ds;
	} instr_word_u;

endpackage

// ==== src.f ====
+incdir+verif
hdl/ppc_isa_pkg.sv
hdl/decode_pkg.sv
hdl/d_format_decoder.sv
hdl/ds_format_decoder.sv
hdl/decode_select.sv
hdl/instr_decode.sv
verif/tb_instr_decode.sv

// ==== verif/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected micro-op for one input cycle.
typedef struct packed {
	logic                  valid;
	logic                  illegal;
	logic [5:0]            opcode;
	logic [3:0]            kind;
	logic [4:0]            reg1;
	logic [4:0]            reg2;
	logic [63:0]           imm;
	logic                  ra_zero;
	logic [addr_width-1:0] pc;
} expect_t;

logic [31:0] rng_state;

// xorshift32 step.
function automatic logic [31:0] next_random();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// true for every primary opcode that has at least one legal form.
function automatic logic is_known_opcode(input logic [5:0] op);
	return op inside {op_addi, op_addis, op_ori, op_lwz, op_stw, op_ds_load, op_ds_store};
endfunction

// picks 0 to 10 are the supported instructions, 11 is an unknown opcode
// and anything above is a DS word with the reserved xo value.
function automatic logic [31:0] build_word(input int unsigned pick, input logic [31:0] r);
	logic [5:0] op;
	logic [31:0] w;
	w = r;
	case (pick)
		0: w[31:26] = op_addi;
		1: w[31:26] = op_addis;
		2: w[31:26] = op_ori;
		3: w[31:26] = op_lwz;
		4: w[31:26] = op_stw;
		5: w = {op_ds_load, r[25:2], xo_ld};
		6: w = {op_ds_load, r[25:2], xo_ldu};
		7: w = {op_ds_load, r[25:2], xo_lwa};
		8: w = {op_ds_store, r[25:2], xo_std};
		9: w = {op_ds_store, r[25:2], xo_stdu};
		10: w = {op_ds_store, r[25:2], xo_stq};
		11: begin
			op = r[31:26];
			while (is_known_opcode(op))
				op = op + 6'd1;
			w[31:26] = op;
		end
		default: w = {(r[0] ? op_ds_load : op_ds_store), r[25:2], 2'b11};
	endcase
	return w;
endfunction

// expected outputs follow the field rules of the architecture.
function automatic expect_t predict_decode(input logic v, input logic [31:0] word,
		input logic [addr_width-1:0] pc);
	expect_t e;
	logic [15:0] d;
	logic [13:0] ds;
	logic [1:0] xo;
	logic hit;
	d = word[15:0];
	ds = word[15:2];
	xo = word[1:0];
	hit = 1'b1;
	e.valid = v;
	e.opcode = word[31:26];
	e.reg1 = word[25:21];
	e.reg2 = word[20:16];
	e.pc = pc;
	e.kind = 4'd0;
	e.ra_zero = 1'b1;
	e.imm = {{48{d[15]}}, d};
	case (e.opcode)
		op_addi: e.kind = k_add;
		op_addis: begin
			e.kind = k_add_shifted;
			e.imm = {{32{d[15]}}, d, 16'h0000};
		end
		op_ori: begin
			e.kind = k_or_imm;
			e.imm = {48'd0, d};
			e.ra_zero = 1'b0;
		end
		op_lwz: e.kind = k_load_word;
		op_stw: e.kind = k_store_word;
		op_ds_load, op_ds_store: begin
			// displacement is a signed word count.
			e.imm = {{48{ds[13]}}, ds, 2'b00};
			case ({e.opcode == op_ds_store, xo})
				3'b000: e.kind = k_load_dword;
				3'b001: e.kind = k_load_dword_upd;
				3'b010: e.kind = k_load_word_alg;
				3'b100: e.kind = k_store_dword;
				3'b101: e.kind = k_store_dword_upd;
				3'b110: e.kind = k_store_quad;
				default: hit = 1'b0;
			endcase
			if (xo == 2'd1)
				e.ra_zero = 1'b0;
		end
		default: hit = 1'b0;
	endcase
	if (!hit)
		e.kind = 4'd0;
	e.illegal = v && !hit;
	return e;
endfunction

`endif

// ==== verif/tb_instr_decode.sv ====
`timescale 1ns/1ps

module tb_instr_decode;

	import ppc_isa_pkg::*;
	import decode_pkg::*;

	localparam int addr_width = 64;
	localparam int clk_period = 4;
	localparam int reset_cycles = 5;
	localparam int num_items = 3000;

	logic clock;
	logic rst_n;
	logic valid_in;
	logic [31:0] instruction;
	logic [addr_width-1:0] pc_in;
	logic valid_out;
	logic illegal_out;
	logic [5:0] opcode_out;
	logic [3:0] kind_out;
	logic [4:0] reg1_out;
	logic [4:0] reg2_out;
	logic [63:0] imm_out;
	logic ra_zero_out;
	logic [addr_width-1:0] pc_out;

	int unsigned errors;
	int unsigned checks;

	`include "decode_model.svh"

	// expectations in flight are two deep like the DUT.
	expect_t exp_q[$];

	instr_decode #(
		.addr_width(addr_width)
	) UUT (
		.clock_i(clock),
		.rst_n_i(rst_n),
		.valid_i(valid_in),
		.instruction_i(instruction),
		.pc_i(pc_in),
		.valid_o(valid_out),
		.illegal_o(illegal_out),
		.opcode_o(opcode_out),
		.kind_o(kind_out),
		.reg1_o(reg1_out),
		.reg2_o(reg2_out),
		.imm_o(imm_out),
		.ra_zero_o(ra_zero_out),
		.pc_o(pc_out)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	// two clock periods per item leaves plenty of slack.
	initial begin
		#((num_items + reset_cycles + 10) * clk_period * 2);
		$display("timeout: the decode run did not reach its end in time");
		$display("Test FAILED");
		$finish;
	end

	task automatic compare_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %h got %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic check_outputs(input expect_t e);
		compare_value("valid_o", 64'(e.valid), 64'(valid_out));
		compare_value("illegal_o", 64'(e.illegal), 64'(illegal_out));
		if (e.valid) begin
			compare_value("opcode_o", 64'(e.opcode), 64'(opcode_out));
			compare_value("kind_o", 64'(e.kind), 64'(kind_out));
			compare_value("pc_o", 64'(e.pc), 64'(pc_out));
			// remaining fields are don't care on illegal words.
			if (!e.illegal) begin
				compare_value("reg1_o", 64'(e.reg1), 64'(reg1_out));
				compare_value("reg2_o", 64'(e.reg2), 64'(reg2_out));
				compare_value("imm_o", e.imm, imm_out);
				compare_value("ra_zero_o", 64'(e.ra_zero), 64'(ra_zero_out));
			end
		end
	endtask

	// checks the item from two cycles back and then drives a new one.
	task automatic run_cycle(input logic v, input logic [31:0] w,
			input logic [addr_width-1:0] p);
		expect_t e;
		if (exp_q.size() == 2) begin
			e = exp_q.pop_front();
			check_outputs(e);
		end
		valid_in = v;
		instruction = w;
		pc_in = p;
		exp_q.push_back(predict_decode(v, w, p));
		@(negedge clock);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] hi;
		logic [31:0] lo;
		int unsigned pick;
		logic v;
		logic [31:0] w;
		logic [addr_width-1:0] p;
		errors = 0;
		checks = 0;
		rng_state = 32'd44626;
		rst_n = 1'b0;
		// an illegal word is offered through reset and must not come out.
		valid_in = 1'b1;
		instruction = '0;
		pc_in = '0;
		repeat (reset_cycles) @(negedge clock);
		compare_value("valid_o", 64'd0, 64'(valid_out));
		compare_value("illegal_o", 64'd0, 64'(illegal_out));
		rst_n = 1'b1;
		// the pipeline is empty for the first two cycles out of reset.
		exp_q.push_back(predict_decode(1'b0, 32'd0, '0));
		exp_q.push_back(predict_decode(1'b0, 32'd0, '0));
		for (int i = 0; i < num_items; i++) begin
			r = next_random();
			pick = r % 13;
			w = build_word(pick, next_random());
			hi = next_random();
			lo = next_random();
			p = {hi, lo[31:2], 2'b00};
			r = next_random();
			v = (r % 8) != 0;
			run_cycle(v, w, p);
		end
		repeat (2) run_cycle(1'b0, 32'd0, '0);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
